//--- design/exec_pkg.sv
package exec_pkg;

	localparam int data_width = 16;
	localparam int reg_addr_width = 4;

	// ALU opcodes, codes 3, 7, 14 and 15 are unused
	typedef enum logic [3:0] {
		add    = 4'h0,
		sub    = 4'h1,
		xor_op = 4'h2,
		sll    = 4'h4,
		sra    = 4'h5,
		ror    = 4'h6,
		red    = 4'h8,
		paddsb = 4'h9,
		add_nf = 4'hA, // Add without flag update
		llb    = 4'hB,
		lhb    = 4'hC,
		pass   = 4'hD
	} alu_op_e;

	typedef enum logic [1:0] {
		shift_left        = 2'd0,
		shift_arith_right = 2'd1,
		rotate_right      = 2'd2
	} shift_mode_e;

	// Control carried from decode on toward memory and writeback
	typedef struct packed {
		logic [reg_addr_width-1:0] rd;
		logic [reg_addr_width-1:0] rs;
		logic [reg_addr_width-1:0] rt;
		logic mem_write_en;
		logic mem_read_en;
		logic reg_write_en;
		logic reg_write_src; // Selects memory data over ALU result
		logic halt;
	} exec_ctrl_t;

	typedef struct packed {
		logic n;
		logic z;
		logic v;
	} alu_flags_t;

endpackage

//--- design/carry_lookahead_adder.sv
`timescale 1ns/1ps

module carry_lookahead_adder (
	input  logic [exec_pkg::data_width-1:0] a,
	input  logic [exec_pkg::data_width-1:0] b,
	input  logic                            cin,
	output logic [exec_pkg::data_width-1:0] sum,
	output logic                            cout
);
	logic [exec_pkg::data_width-1:0] g;
	logic [exec_pkg::data_width-1:0] p;
	logic [exec_pkg::data_width-1:0] c; // Carry into each bit
	logic [3:0] grp_g;
	logic [3:0] grp_p;
	logic [4:0] grp_c; // Carry into each group, top bit is carry out

	assign g = a & b;
	assign p = a ^ b;

	// First level, lookahead inside each 4-bit group
	for (genvar k = 0; k < 4; k++) begin : gen_group
		assign grp_g[k] = g[4*k+3] | (p[4*k+3] & g[4*k+2]) | (p[4*k+3] & p[4*k+2] & g[4*k+1])
			| (p[4*k+3] & p[4*k+2] & p[4*k+1] & g[4*k]);
		assign grp_p[k] = &p[4*k +: 4];
		assign c[4*k]   = grp_c[k];
		assign c[4*k+1] = g[4*k] | (p[4*k] & grp_c[k]);
		assign c[4*k+2] = g[4*k+1] | (p[4*k+1] & g[4*k]) | (p[4*k+1] & p[4*k] & grp_c[k]);
		assign c[4*k+3] = g[4*k+2] | (p[4*k+2] & g[4*k+1]) | (p[4*k+2] & p[4*k+1] & g[4*k])
			| (p[4*k+2] & p[4*k+1] & p[4*k] & grp_c[k]);
	end

	// Second level across the groups
	assign grp_c[0] = cin;
	assign grp_c[1] = grp_g[0] | (grp_p[0] & cin);
	assign grp_c[2] = grp_g[1] | (grp_p[1] & grp_g[0]) | (grp_p[1] & grp_p[0] & cin);
	assign grp_c[3] = grp_g[2] | (grp_p[2] & grp_g[1]) | (grp_p[2] & grp_p[1] & grp_g[0])
		| (grp_p[2] & grp_p[1] & grp_p[0] & cin);
	assign grp_c[4] = grp_g[3] | (grp_p[3] & grp_g[2]) | (grp_p[3] & grp_p[2] & grp_g[1])
		| (grp_p[3] & grp_p[2] & grp_p[1] & grp_g[0])
		| (grp_p[3] & grp_p[2] & grp_p[1] & grp_p[0] & cin);

	assign sum  = p ^ c;
	assign cout = grp_c[4];

endmodule

//--- design/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter (
	input  logic [exec_pkg::data_width-1:0] shift_in,
	input  logic [3:0]                      amount,
	input  exec_pkg::shift_mode_e           mode,
	output logic [exec_pkg::data_width-1:0] shift_out
);
	// Stage i feeds the level that moves by 2**i
	logic [exec_pkg::data_width-1:0] stage [0:4];

	assign stage[0] = shift_in;

	for (genvar i = 0; i < 4; i++) begin : gen_level
		logic [exec_pkg::data_width-1:0] moved;

		always_comb begin
			case (mode)
				exec_pkg::shift_left:
					moved = {stage[i][exec_pkg::data_width-1-2**i:0], {(2**i){1'b0}}};
				exec_pkg::shift_arith_right: // Sign fill
					moved = {{(2**i){stage[i][exec_pkg::data_width-1]}},
						stage[i][exec_pkg::data_width-1:2**i]};
				exec_pkg::rotate_right:
					moved = {stage[i][2**i-1:0], stage[i][exec_pkg::data_width-1:2**i]};
				default:
					moved = stage[i]; // Unused mode code
			endcase
		end

		// Bypass this level when its amount bit is clear
		assign stage[i+1] = amount[i] ? moved : stage[i];
	end

	assign shift_out = stage[4];

endmodule

//--- design/byte_reduction_unit.sv
`timescale 1ns/1ps

module byte_reduction_unit (
	input  logic [exec_pkg::data_width-1:0] rs,
	input  logic [exec_pkg::data_width-1:0] rt,
	output logic [exec_pkg::data_width-1:0] rd
);
	logic [8:0] high_sum;  // rs high byte plus rt high byte
	logic [8:0] low_sum;   // rs low byte plus rt low byte
	logic [9:0] total;

	// Pairwise sums, each byte sign-extended to 9 bits so nothing overflows
	assign high_sum = {rs[15], rs[15:8]} + {rt[15], rt[15:8]};
	assign low_sum  = {rs[7], rs[7:0]} + {rt[7], rt[7:0]};

	// Second level of the tree
	assign total = {high_sum[8], high_sum} + {low_sum[8], low_sum};

	assign rd = {{(exec_pkg::data_width-10){total[9]}}, total};

endmodule

//--- design/nibble_sat_adder.sv
`timescale 1ns/1ps

module nibble_sat_adder (
	input  logic [exec_pkg::data_width-1:0] a,
	input  logic [exec_pkg::data_width-1:0] b,
	output logic [exec_pkg::data_width-1:0] sum
);
	// Lanes are independent, no carry crosses a nibble boundary
	for (genvar k = 0; k < 4; k++) begin : gen_lane
		logic [3:0] raw;
		logic       ovf;

		assign raw = a[4*k +: 4] + b[4*k +: 4];

		// Same operand signs but a different result sign
		assign ovf = (a[4*k+3] == b[4*k+3]) && (raw[3] != a[4*k+3]);

		// Clamp to -8 or +7
		assign sum[4*k +: 4] = ovf ? (a[4*k+3] ? 4'h8 : 4'h7) : raw;
	end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [exec_pkg::data_width-1:0] reg_rs,
	input  logic [exec_pkg::data_width-1:0] reg_rt,
	input  logic [exec_pkg::data_width-1:0] imm,
	input  logic [exec_pkg::data_width-1:0] pc_plus2,
	input  logic                            alu_src1,
	input  logic                            alu_src2,
	input  exec_pkg::alu_op_e               alu_op,
	input  exec_pkg::exec_ctrl_t            ctrl_in,
	output logic [exec_pkg::data_width-1:0] alu_result,
	output exec_pkg::alu_flags_t            flags,
	output logic                            flag_update,
	output exec_pkg::exec_ctrl_t            ctrl_out,
	output logic [exec_pkg::data_width-1:0] reg_rt_out
);
	logic [exec_pkg::data_width-1:0] rs_q;
	logic [exec_pkg::data_width-1:0] rt_q;
	logic [exec_pkg::data_width-1:0] imm_q;
	logic [exec_pkg::data_width-1:0] pc_q;
	logic                            src1_sel_q;
	logic                            src2_sel_q;
	exec_pkg::alu_op_e               op_q;
	exec_pkg::exec_ctrl_t            ctrl_q;

	logic [exec_pkg::data_width-1:0] src1;
	logic [exec_pkg::data_width-1:0] src2;
	logic                            is_sub;
	logic [exec_pkg::data_width-1:0] adder_b;
	logic [exec_pkg::data_width-1:0] adder_sum;
	logic [exec_pkg::data_width-1:0] sat_sum;
	logic                            overflow;
	exec_pkg::shift_mode_e           shift_mode;
	logic [exec_pkg::data_width-1:0] shift_res;
	logic [exec_pkg::data_width-1:0] red_res;
	logic [exec_pkg::data_width-1:0] paddsb_res;
	exec_pkg::alu_flags_t            new_flags;

	// Input registers take one instruction per cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			rs_q       <= '0;
			rt_q       <= '0;
			imm_q      <= '0;
			pc_q       <= '0;
			src1_sel_q <= 1'b0;
			src2_sel_q <= 1'b0;
			op_q       <= exec_pkg::add;
			ctrl_q     <= '0;
		end else begin
			rs_q       <= reg_rs;
			rt_q       <= reg_rt;
			imm_q      <= imm;
			pc_q       <= pc_plus2;
			src1_sel_q <= alu_src1;
			src2_sel_q <= alu_src2;
			op_q       <= alu_op;
			ctrl_q     <= ctrl_in;
		end
	end

	assign src1 = src1_sel_q ? pc_q : rs_q;
	assign src2 = src2_sel_q ? imm_q : rt_q;

	// Subtract as src1 + ~src2 + 1
	assign is_sub  = (op_q == exec_pkg::sub);
	assign adder_b = is_sub ? ~src2 : src2;

	carry_lookahead_adder i_cla (
		.a    (src1),
		.b    (adder_b),
		.cin  (is_sub),
		.sum  (adder_sum),
		.cout ()
	);

	assign overflow = (src1[exec_pkg::data_width-1] == adder_b[exec_pkg::data_width-1])
		&& (adder_sum[exec_pkg::data_width-1] != src1[exec_pkg::data_width-1]);
	// Positive overflow wraps negative, so clamp by the sum sign
	assign sat_sum = !overflow ? adder_sum
		: adder_sum[exec_pkg::data_width-1] ? {1'b0, {(exec_pkg::data_width-1){1'b1}}}
		: {1'b1, {(exec_pkg::data_width-1){1'b0}}};

	always_comb begin
		case (op_q)
			exec_pkg::sra: shift_mode = exec_pkg::shift_arith_right;
			exec_pkg::ror: shift_mode = exec_pkg::rotate_right;
			default:       shift_mode = exec_pkg::shift_left;
		endcase
	end

	barrel_shifter i_shifter (
		.shift_in  (src1),
		.amount    (src2[3:0]),
		.mode      (shift_mode),
		.shift_out (shift_res)
	);

	byte_reduction_unit i_red (
		.rs (src1),
		.rt (src2),
		.rd (red_res)
	);

	nibble_sat_adder i_psa (
		.a   (src1),
		.b   (src2),
		.sum (paddsb_res)
	);

	always_comb begin
		case (op_q)
			exec_pkg::add,
			exec_pkg::sub:    alu_result = sat_sum;
			exec_pkg::add_nf: alu_result = adder_sum; // Wraps
			exec_pkg::xor_op: alu_result = src1 ^ src2;
			exec_pkg::sll,
			exec_pkg::sra,
			exec_pkg::ror:    alu_result = shift_res;
			exec_pkg::red:    alu_result = red_res;
			exec_pkg::paddsb: alu_result = paddsb_res;
			exec_pkg::llb:    alu_result = {src1[15:8], src2[7:0]};
			exec_pkg::lhb:    alu_result = {src2[7:0], src1[7:0]};
			exec_pkg::pass:   alu_result = src1;
			default:          alu_result = '0;
		endcase
	end

	assign new_flags.n = alu_result[exec_pkg::data_width-1];
	assign new_flags.z = (alu_result == '0);
	assign new_flags.v = overflow;

	// Codes from red upward leave the flags alone
	assign flag_update = (op_q < exec_pkg::red);

	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else if (flag_update) begin
			if (op_q == exec_pkg::add || is_sub) begin
				flags <= new_flags;
			end else if (op_q == exec_pkg::xor_op || op_q == exec_pkg::sll
					|| op_q == exec_pkg::sra || op_q == exec_pkg::ror) begin
				flags.z <= new_flags.z; // Logic and shift ops
			end
		end
	end

	assign ctrl_out   = ctrl_q;
	assign reg_rt_out = rt_q;

endmodule

//--- testbench/tb_execute_stage.sv
`timescale 1ns/1ps

module tb_execute_stage;

	typedef struct packed {
		logic [3:0]           op;
		logic [15:0]          rs;
		logic [15:0]          rt;
		logic [15:0]          imm;
		logic [15:0]          pc;
		logic                 src1;
		logic                 src2;
		exec_pkg::exec_ctrl_t ctrl;
	} instr_t;

	typedef struct packed {
		logic [15:0]          result;
		logic                 flag_update;
		exec_pkg::alu_flags_t flags; // Flags after this instruction
	} ref_t;

	// One entry per issued instruction that is checked on its due edge
	typedef struct packed {
		int                   due;
		logic [3:0]           test;
		logic                 last;
		logic [15:0]          result;
		logic                 flag_update;
		exec_pkg::exec_ctrl_t ctrl;
		logic [15:0]          rt_out;
		exec_pkg::alu_flags_t flags; // Flags seen while this one executes
	} expect_t;

	logic                 clk = 1'b0;
	logic                 rst;
	logic [15:0]          reg_rs;
	logic [15:0]          reg_rt;
	logic [15:0]          imm;
	logic [15:0]          pc_plus2;
	logic                 alu_src1;
	logic                 alu_src2;
	exec_pkg::alu_op_e    alu_op;
	exec_pkg::exec_ctrl_t ctrl_in;
	logic [15:0]          alu_result;
	exec_pkg::alu_flags_t flags;
	logic                 flag_update;
	exec_pkg::exec_ctrl_t ctrl_out;
	logic [15:0]          reg_rt_out;

	exec_pkg::alu_flags_t model_flags = '0;
	expect_t              exp_q [$];
	logic [15:0]          lfsr = 16'd90;
	int                   cycle = 0;
	int                   checks = 0;
	int                   errors = 0;
	int                   tests_done = 0;
	int                   test_errs [6] = '{0, 0, 0, 0, 0, 0};

	execute_stage i_dut (
		.clk         (clk),
		.rst         (rst),
		.reg_rs      (reg_rs),
		.reg_rt      (reg_rt),
		.imm         (imm),
		.pc_plus2    (pc_plus2),
		.alu_src1    (alu_src1),
		.alu_src2    (alu_src2),
		.alu_op      (alu_op),
		.ctrl_in     (ctrl_in),
		.alu_result  (alu_result),
		.flags       (flags),
		.flag_update (flag_update),
		.ctrl_out    (ctrl_out),
		.reg_rt_out  (reg_rt_out)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle++;
		if (cycle >= 2000) begin
			$display("Run timed out after %0d cycles with tests still pending", cycle);
			$display("Test failed");
			$finish;
		end
	end

	function automatic string test_label(int id);
		case (id)
			0:       return "reset";
			1:       return "adder";
			2:       return "shift_xor";
			3:       return "red_paddsb";
			4:       return "byte_pass";
			default: return "stream";
		endcase
	endfunction

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_step();
		logic out_bit;
		out_bit = lfsr[0];
		lfsr = lfsr >> 1;
		if (out_bit)
			lfsr = lfsr ^ 16'hB400;
		return out_bit;
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_step()};
		return v;
	endfunction

	function automatic ref_t alu_ref(logic [3:0] op, logic [15:0] a, logic [15:0] b,
			exec_pkg::alu_flags_t f_in);
		ref_t        r;
		int          sa;
		int          sb;
		int          total;
		logic [31:0] dbl;
		r.flags = f_in;
		r.flag_update = (op < 4'h8);
		r.result = '0;
		sa = int'($signed(a));
		sb = int'($signed(b));
		case (op)
			4'h0, 4'h1: begin
				total = (op == 4'h1) ? sa - sb : sa + sb;
				if (total > 32767)
					r.result = 16'h7FFF;
				else if (total < -32768)
					r.result = 16'h8000;
				else
					r.result = total[15:0];
				r.flags.v = (total > 32767) || (total < -32768);
			end
			4'h2: r.result = a ^ b;
			4'h4: r.result = a << b[3:0];
			4'h5: r.result = $signed(a) >>> b[3:0];
			4'h6: begin
				dbl = {a, a} >> b[3:0];
				r.result = dbl[15:0];
			end
			4'h8: begin
				total = int'($signed(a[15:8])) + int'($signed(a[7:0]))
					+ int'($signed(b[15:8])) + int'($signed(b[7:0]));
				r.result = total[15:0];
			end
			4'h9: begin
				for (int k = 0; k < 4; k++) begin
					total = int'($signed(a[4*k +: 4])) + int'($signed(b[4*k +: 4]));
					if (total > 7)
						total = 7;
					else if (total < -8)
						total = -8;
					r.result[4*k +: 4] = total[3:0];
				end
			end
			4'hA: r.result = a + b; // Wraps
			4'hB: r.result = {a[15:8], b[7:0]};
			4'hC: r.result = {b[7:0], a[7:0]};
			4'hD: r.result = a;
			default: r.result = '0;
		endcase
		if (op <= 4'h1) begin
			r.flags.n = r.result[15];
			r.flags.z = (r.result == '0);
		end else if (op == 4'h2 || op == 4'h4 || op == 4'h5 || op == 4'h6) begin
			r.flags.z = (r.result == '0); // Xor and shifts load z only
		end
		return r;
	endfunction

	task automatic check(int id, string what, logic [31:0] exp, logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			test_errs[id]++;
			$display("error %s %s: expected %h, actual %h", test_label(id), what, exp, act);
		end
	endtask

	task automatic check_reset_state();
		check(0, "ctrl_out", 32'd0, ctrl_out);
		check(0, "flags", 32'd0, flags);
		check(0, "alu_result", 32'd0, alu_result);
		check(0, "flag_update", 32'd1, flag_update);
	endtask

	task automatic issue(int id, instr_t ins, logic last);
		expect_t     e;
		ref_t        r;
		logic [15:0] s1;
		logic [15:0] s2;
		@(posedge clk);
		#2;
		rst = 1'b0;
		reg_rs = ins.rs;
		reg_rt = ins.rt;
		imm = ins.imm;
		pc_plus2 = ins.pc;
		alu_src1 = ins.src1;
		alu_src2 = ins.src2;
		alu_op = exec_pkg::alu_op_e'(ins.op);
		ctrl_in = ins.ctrl;
		s1 = ins.src1 ? ins.pc : ins.rs;
		s2 = ins.src2 ? ins.imm : ins.rt;
		r = alu_ref(ins.op, s1, s2, model_flags);
		e.due = cycle + 1; // Sampled on the next edge
		e.test = 4'(id);
		e.last = last;
		e.result = r.result;
		e.flag_update = r.flag_update;
		e.ctrl = ins.ctrl;
		e.rt_out = ins.rt;
		e.flags = model_flags;
		model_flags = r.flags;
		exp_q.push_back(e);
	endtask

	// Operand a goes through pc_plus2 when sel[0] is set, b through imm when sel[1] is set
	task automatic run_op(int id, logic [3:0] op, logic [15:0] a, logic [15:0] b,
			logic [1:0] sel);
		instr_t ins;
		ins.op = op;
		ins.src1 = sel[0];
		ins.src2 = sel[1];
		ins.rs = sel[0] ? 16'(rand_bits(16)) : a;
		ins.pc = sel[0] ? a : 16'(rand_bits(16));
		ins.rt = sel[1] ? 16'(rand_bits(16)) : b;
		ins.imm = sel[1] ? b : 16'(rand_bits(16));
		ins.ctrl = 17'(rand_bits(17));
		issue(id, ins, 1'b0);
	endtask

	// Bubble that closes a test and checks its final flags
	task automatic end_test(int id);
		instr_t ins;
		ins = '0;
		ins.op = 4'hD;
		issue(id, ins, 1'b1);
	endtask

	initial begin : compare
		expect_t e;
		forever begin
			@(posedge clk);
			#10;
			if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
				e = exp_q.pop_front();
				check(e.test, "alu_result", e.result, alu_result);
				check(e.test, "flag_update", e.flag_update, flag_update);
				check(e.test, "ctrl_out", e.ctrl, ctrl_out);
				check(e.test, "reg_rt_out", e.rt_out, reg_rt_out);
				check(e.test, "flags", e.flags, flags);
				if (e.last) begin
					$display("%-10s done, %0d errors", test_label(e.test), test_errs[e.test]);
					tests_done++;
				end
			end
		end
	end

	initial begin : stimulus
		instr_t     ins;
		ref_t       reset_ref;
		logic [3:0] op;
		logic [15:0] a;
		logic [3:0] byte_ops [0:6];
		rst = 1'b1;
		reg_rs = '0;
		reg_rt = '0;
		imm = '0;
		pc_plus2 = '0;
		alu_src1 = 1'b0;
		alu_src2 = 1'b0;
		alu_op = exec_pkg::add;
		ctrl_in = '0;
		byte_ops = '{4'hB, 4'hC, 4'hD, 4'h3, 4'h7, 4'hE, 4'hF};

		// Reset held through edge 8 and released by the first issue
		for (int i = 1; i <= 7; i++) begin
			@(posedge clk);
			#10;
			check_reset_state();
		end
		// The reset state runs as an add of zeros on the first edge after release
		reset_ref = alu_ref(4'h0, 16'h0000, 16'h0000, model_flags);
		model_flags = reset_ref.flags;
		ins = '0;
		issue(0, ins, 1'b0);
		end_test(0);

		run_op(1, 4'h0, 16'h7FFF, 16'h0001, 2'b00);
		run_op(1, 4'h0, 16'h8000, 16'hFFFF, 2'b01);
		run_op(1, 4'h1, 16'h8000, 16'h0001, 2'b10);
		run_op(1, 4'h1, 16'h7FFF, 16'hFFFF, 2'b11);
		run_op(1, 4'h0, 16'h0001, 16'hFFFF, 2'b00);
		run_op(1, 4'h1, 16'h1234, 16'h1234, 2'b01);
		run_op(1, 4'h1, 16'h0000, 16'h8000, 2'b00);
		run_op(1, 4'hA, 16'h7FFF, 16'h0001, 2'b10);
		run_op(1, 4'hA, 16'h8000, 16'h8000, 2'b11);
		run_op(1, 4'h0, 16'h1234, 16'h0010, 2'b11);
		for (int i = 0; i < 30; i++) begin
			case (rand_bits(2))
				0:       op = 4'h1;
				1:       op = 4'hA;
				default: op = 4'h0;
			endcase
			run_op(1, op, 16'(rand_bits(16)), 16'(rand_bits(16)), 2'(rand_bits(2)));
		end
		end_test(1);

		run_op(2, 4'h0, 16'h8000, 16'hFFFF, 2'b00); // n and v set beforehand
		for (int amt = 0; amt < 16; amt++) begin
			run_op(2, 4'h4, 16'(rand_bits(16)), {12'(rand_bits(12)), 4'(amt)}, 2'(amt));
			run_op(2, 4'h5, 16'(rand_bits(16)), {12'(rand_bits(12)), 4'(amt)}, 2'(amt));
			run_op(2, 4'h6, 16'(rand_bits(16)), {12'(rand_bits(12)), 4'(amt)}, 2'(amt));
		end
		run_op(2, 4'h4, 16'h0100, 16'h0008, 2'b00); // Shifted out to zero
		a = 16'(rand_bits(16));
		run_op(2, 4'h2, a, a, 2'b11);
		run_op(2, 4'h2, a, ~a, 2'b01);
		end_test(2);

		run_op(3, 4'h1, 16'h0000, 16'h0001, 2'b00);
		run_op(3, 4'h8, 16'h7F7F, 16'h7F7F, 2'b00);
		run_op(3, 4'h8, 16'h8080, 16'h8080, 2'b11);
		run_op(3, 4'h9, 16'h7777, 16'h1111, 2'b01);
		run_op(3, 4'h9, 16'h8888, 16'hFFFF, 2'b10);
		run_op(3, 4'h9, 16'h7878, 16'h1818, 2'b00); // Lanes clamp both ways
		for (int i = 0; i < 30; i++) begin
			op = rand_bits(1) ? 4'h9 : 4'h8;
			run_op(3, op, 16'(rand_bits(16)), 16'(rand_bits(16)), 2'(rand_bits(2)));
		end
		end_test(3);

		run_op(4, 4'h0, 16'h8000, 16'h8000, 2'b00);
		for (int i = 0; i < 21; i++)
			run_op(4, byte_ops[i % 7], 16'(rand_bits(16)), 16'(rand_bits(16)),
				2'(rand_bits(2)));
		end_test(4);

		for (int i = 0; i < 400; i++)
			run_op(5, 4'(rand_bits(4)), 16'(rand_bits(16)), 16'(rand_bits(16)),
				2'(rand_bits(2)));
		end_test(5);

		wait (tests_done == 6);
		$display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- files.f
design/exec_pkg.sv
design/carry_lookahead_adder.sv
design/barrel_shifter.sv
design/byte_reduction_unit.sv
design/nibble_sat_adder.sv
design/execute_stage.sv
testbench/tb_execute_stage.sv
